/* inner_shuffle.f */
+incdir+hw
hw/shuffle_pkg.sv
hw/bank_array.sv
hw/write_sched.sv
hw/page_ctrl.sv
hw/read_sched.sv
hw/skid_buffer.sv
hw/inner_shuffle.sv
bench/shuffle_assertions.sv
bench/shuffle_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module shuffle_tb \
		-f inner_shuffle.f -o shuffle_sim
	out=$$(./obj_dir/shuffle_sim); echo "$$out"; echo "$$out" | grep -q "PASS: all tests"

clean:
	rm -rf obj_dir

/* bench/shuffle_tb.sv */
// --------------------
// Transpose unit testbench
// Five random jobs in three phases of input gaps and output stalls
// --------------------
`timescale 1ns/1ns
`include "shuffle_settings.svh"

module shuffle_tb
	import shuffle_pkg::*;
();

	localparam int JOB_BEATS = `SHUF_I * `SHUF_J / `SHUF_SIMD;
	localparam int WAIT_LIMIT = 4000; // Cycles per phase

	logic clk = 1'b0;
	logic rst = 1'b1;
	beat_t idat = '0;
	logic ivld = 1'b0;
	logic irdy;
	beat_t odat;
	logic ovld;
	logic ordy = 1'b0;

	logic [31:0] lfsr = 32'ha739_8d45;
	int in_count = 0; // Input beats accepted
	int out_count = 0; // Output beats taken
	int in_goal = 0; // Input beats to send so far
	logic in_fire = 1'b0; // Current input beat goes on the next edge
	logic ivld_gaps = 1'b1;
	int ordy_mode = 1; // 0 always ready, 1 mostly ready, 2 rarely ready

	inner_shuffle dut0 (.clk, .rst, .idat, .ivld, .irdy, .odat, .ovld, .ordy);

	always #2 clk = ~clk;

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
		end
		return v;
	endfunction

	// --------------------
	// Handshakes looked at mid-cycle where all signals have settled
	always @(negedge clk) begin
		in_fire = ivld && irdy;
		if (in_fire) in_count++;
		if (ovld && ordy) out_count++;
		if (dut0.chk0.fail_cnt != 0) begin
			$display("FAIL: see errors above");
			$fatal(1, "The checker reported an assertion failure");
		end
	end

	// Stimulus on the rising edge
	always @(posedge clk) begin
		if (!rst) begin
			if (!ivld || in_fire) begin // Hold a beat until taken
				if (in_count < in_goal && (!ivld_gaps || rand_bits(2) != 0)) begin
					ivld <= 1'b1;
					for (int l = 0; l < `SHUF_SIMD; l++) begin
						idat[l] <= elem_t'(rand_bits(`SHUF_BITS));
					end
				end else begin
					ivld <= 1'b0;
				end
			end
			if (ordy_mode == 0) ordy <= 1'b1;
			else if (ordy_mode == 1) ordy <= (rand_bits(2) != 0); // 3 of 4 cycles
			else ordy <= (rand_bits(2) == 0); // 1 of 4 cycles
		end
	end

	// Send jobs and wait until all their beats are out
	task automatic run_jobs(int jobs, logic gaps, int mode);
		int cycles = 0;
		@(negedge clk);
		ivld_gaps = gaps;
		ordy_mode = mode;
		in_goal += jobs * JOB_BEATS;
		while (out_count < in_goal) begin
			@(posedge clk);
			cycles++;
			if (cycles > WAIT_LIMIT) begin
				$display("Timeout: %0d of %0d output beats after %0d cycles",
					out_count, in_goal, cycles);
				$display("FAIL: see errors above");
				$fatal(1, "Output beats did not arrive in time");
			end
		end
	endtask

	// --------------------
	initial begin
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		run_jobs(1, 1'b1, 1); // Job 0 with gaps on both streams
		run_jobs(2, 1'b0, 0); // Jobs 1 and 2 back to back with ordy held high
		run_jobs(2, 1'b0, 2); // Jobs 3 and 4 where slow output backs up the input
		@(negedge clk); // Checker results of the last edge settle first
		if (dut0.chk0.fail_cnt != 0) begin
			$display("FAIL: see errors above");
			$fatal(1, "The checker reported an assertion failure");
		end else begin
			$display("PASS: all tests");
			$finish;
		end
	end

endmodule

/* bench/shuffle_assertions.sv */
// --------------------
// Transpose checker
// Column-major reference model and stream protocol assertions,
// bound onto the transpose unit ports
// --------------------
`timescale 1ns/1ns
`include "shuffle_settings.svh"

module shuffle_checker
	import shuffle_pkg::*;
(
	input logic clk,
	input logic rst,
	input beat_t idat,
	input logic ivld,
	input logic irdy,
	input beat_t odat,
	input logic ovld,
	input logic ordy
);

	localparam int JOB_BEATS = `SHUF_I * `SHUF_J / `SHUF_SIMD;
	localparam int ROW_BLOCKS = `SHUF_I / `SHUF_SIMD; // Output beats per column
	localparam int RING_BEATS = 4 * JOB_BEATS; // Input is never more than two jobs ahead

	beat_t in_ring [RING_BEATS]; // Accepted input beats, four jobs deep
	int in_cnt; // Accepted input beats
	int out_cnt; // Taken output beats
	int fail_cnt = 0; // Failed assertions so far
	beat_t exp_dat;

	always_ff @(posedge clk) begin
		if (rst) begin
			in_cnt <= 0;
			out_cnt <= 0;
		end else begin
			if (ivld && irdy) begin
				in_ring[in_cnt % RING_BEATS] <= idat;
				in_cnt <= in_cnt + 1;
			end
			if (ovld && ordy) out_cnt <= out_cnt + 1;
		end
	end

	// --------------------
	// Beat k is column k/ROW_BLOCKS, rows from SIMD*(k mod ROW_BLOCKS)
	always_comb begin
		int base;
		int k;
		int n;
		base = ((out_cnt / JOB_BEATS) % 4) * JOB_BEATS; // Job start in the ring
		k = out_cnt % JOB_BEATS;
		for (int l = 0; l < `SHUF_SIMD; l++) begin
			n = (`SHUF_SIMD * (k % ROW_BLOCKS) + l) * `SHUF_J + k / ROW_BLOCKS;
			exp_dat[l] = in_ring[base + n / `SHUF_SIMD][n % `SHUF_SIMD]; // Element n of the job
		end
	end

	// --------------------
	a_reset_idle: assert property (@(posedge clk) rst |=> !ovld && irdy)
		else begin
			fail_cnt++;
			$error("ERR %0t: ovld high or irdy low around reset", $time);
		end

	a_order: assert property (@(posedge clk) disable iff (rst) ovld |-> odat == exp_dat)
		else begin
			fail_cnt++;
			$error("ERR %0t: output beat %0d is %h, expected %h", $time,
				$sampled(out_cnt), $sampled(odat), $sampled(exp_dat));
		end

	// Whole job written before any of its beats leaves
	a_job_whole: assert property (@(posedge clk) disable iff (rst)
		ovld |-> in_cnt >= (out_cnt / JOB_BEATS + 1) * JOB_BEATS)
		else begin
			fail_cnt++;
			$error("ERR %0t: output beat %0d before its job was complete", $time,
				$sampled(out_cnt));
		end

	a_hold: assert property (@(posedge clk) disable iff (rst)
		ovld && !ordy |=> ovld && $stable(odat))
		else begin
			fail_cnt++;
			$error("ERR %0t: stalled output beat dropped or changed", $time);
		end

	// Input only stalls with two jobs buffered
	a_input_stall: assert property (@(posedge clk) disable iff (rst)
		!irdy |-> in_cnt / JOB_BEATS - out_cnt / JOB_BEATS >= 2)
		else begin
			fail_cnt++;
			$error("ERR %0t: irdy low with %0d input and %0d output beats", $time,
				$sampled(in_cnt), $sampled(out_cnt));
		end

endmodule

bind inner_shuffle shuffle_checker chk0 (.clk, .rst, .idat, .ivld, .irdy, .odat, .ovld, .ordy);

/* hw/inner_shuffle.sv */
// --------------------
// Streaming transpose unit
// Takes an I x J job row-major, SIMD elements per beat, and
// returns it column-major. Two bank pages overlap write and read
// --------------------
`timescale 1ns/1ns
`include "shuffle_settings.svh"

module inner_shuffle
	import shuffle_pkg::*;
(
	input logic clk,
	input logic rst,

	input beat_t idat, // Input stream
	input logic ivld,
	output logic irdy,

	output beat_t odat, // Output stream
	output logic ovld,
	input logic ordy
);

	bank_wr_t bank_wr;
	logic wr_page_done;
	logic wr_page;
	logic rd_allowed;
	logic rd_page;
	logic rd_page_done;
	logic rd_en;
	bank_addr_vec_t rd_addr;
	beat_t bank_q;
	logic obuf_vld; // Read side to skid buffer
	beat_t obuf_dat;
	logic obuf_rdy;

	// Column slices only map onto distinct banks for whole row blocks
	initial begin
		if (`SHUF_I % `SHUF_SIMD != 0) begin
			$fatal(1, "inner_shuffle: I is not a multiple of SIMD");
		end
	end

	write_sched wr_sched0 (.clk, .rst, .idat, .ivld, .irdy, .bank_wr, .wr_page_done, .wr_page);

	page_ctrl page_ctrl0 (.clk, .rst, .wr_page_done, .wr_page, .rd_page_done,
		.irdy, .rd_allowed, .rd_page);

	bank_array banks0 (.clk, .bank_wr, .rd_en, .rd_addr, .bank_q);

	read_sched rd_sched0 (.clk, .rst, .rd_allowed, .rd_page, .rd_page_done,
		.rd_en, .rd_addr, .bank_q, .obuf_vld, .obuf_dat, .obuf_rdy);

	skid_buffer oskid0 (.clk, .rst, .obuf_vld, .obuf_dat, .obuf_rdy, .ovld, .odat, .ordy);

endmodule

/* hw/skid_buffer.sv */
// --------------------
// Output skid buffer
// Main and skid register for beats, ready towards the
// read side comes straight from a flop
// --------------------
`timescale 1ns/1ns

module skid_buffer
	import shuffle_pkg::*;
(
	input logic clk,
	input logic rst,

	input logic obuf_vld, // From read_sched
	input beat_t obuf_dat,
	output logic obuf_rdy,

	output logic ovld, // Output stream
	output beat_t odat,
	input logic ordy
);

	logic skid_vld; // Skid register occupied
	beat_t skid_dat;
	logic in_fire;
	logic main_free; // Main register empty or being taken

	assign in_fire = obuf_vld && obuf_rdy;
	assign main_free = !ovld || ordy;
	assign obuf_rdy = !skid_vld;

	always_ff @(posedge clk) begin
		if (rst) begin
			ovld <= 1'b0;
			skid_vld <= 1'b0;
		end else if (main_free) begin
			ovld <= skid_vld || in_fire; // Skid drains first, no input then
			skid_vld <= 1'b0;
		end else if (in_fire) begin
			skid_vld <= 1'b1; // Main stalled, park the beat
		end
	end

	always_ff @(posedge clk) begin
		if (main_free) begin
			if (skid_vld) odat <= skid_dat;
			else if (in_fire) odat <= obuf_dat;
		end else if (in_fire) begin
			skid_dat <= obuf_dat;
		end
	end

endmodule

/* hw/read_sched.sv */
// --------------------
// Read scheduler
// Walks the job column by column, SIMD rows per read, and
// steers one address to each bank from the rotating bank pattern.
// Bank data is put back into lane order one cycle later
// --------------------
`timescale 1ns/1ns
`include "shuffle_settings.svh"

module read_sched
	import shuffle_pkg::*;
(
	input logic clk,
	input logic rst,

	input logic rd_allowed, // Current read page is full
	input logic rd_page,
	output logic rd_page_done, // Last read of the page accepted

	output logic rd_en,
	output bank_addr_vec_t rd_addr,
	input beat_t bank_q,

	output logic obuf_vld, // Beat towards the skid buffer
	output beat_t obuf_dat,
	input logic obuf_rdy
);

	typedef logic [$clog2(`SHUF_I+1)-1:0] row_t;
	typedef logic [$clog2(`SHUF_J+1)-1:0] col_t;

	localparam lane_vec_t RD_INIT_PAT = init_rd_pattern();
	localparam lane_vec_t RD_INIT_INV = inv_rd_pattern(RD_INIT_PAT);
	localparam lane_vec_t RD_PERM = rd_perm_pattern();
	localparam bank_addr_vec_t RD_ADDR_INIT = init_rd_addr();
	localparam bank_addr_t ROW_STEP = bank_addr_t'(`SHUF_J); // Next SIMD rows
	localparam bank_addr_t COL_REWIND = bank_addr_t'((RD_ROT_PERIOD - 1) * `SHUF_J);
	localparam row_t ROW_LAST = row_t'(`SHUF_I - `SHUF_SIMD);
	localparam col_t COL_LAST = col_t'(`SHUF_J - 1);

	row_t rd_row; // 0, SIMD, .., I-SIMD
	col_t rd_col; // 0 .. J-1
	logic rd_go; // Read issued this cycle
	logic row_last;
	logic col_last;
	logic page_end;
	bank_addr_vec_t lane_addr; // Word of each lane within the page
	logic [`SHUF_SIMD-1:0] hor_inc; // Lane row crosses a word at the next column
	lane_vec_t rd_pat; // Bank read by each lane
	lane_vec_t rd_inv; // Lane served by each bank
	lane_vec_t pat_next;
	lane_vec_t inv_next;
	lane_vec_t rd_pat_q; // Pattern of the read in flight
	bank_addr_t page_base;

	assign rd_go = rd_allowed && obuf_rdy;
	assign rd_en = rd_go;
	assign row_last = (rd_row == ROW_LAST);
	assign col_last = (rd_col == COL_LAST);
	assign page_end = row_last && col_last;
	assign rd_page_done = rd_go && page_end;

	// --------------------
	// Column/row cursor
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_row <= '0;
			rd_col <= '0;
		end else if (rd_go) begin
			if (row_last) begin
				rd_row <= '0;
				rd_col <= col_last ? '0 : rd_col + col_t'(1);
			end else begin
				rd_row <= rd_row + row_t'(`SHUF_SIMD);
			end
		end
	end

	always_comb begin
		for (int l = 0; l < `SHUF_SIMD; l++) begin
			hor_inc[l] = ((l * `SHUF_J + int'(rd_col) + 1) % `SHUF_SIMD) == 0;
			pat_next[l] = rd_pat[RD_PERM[l]]; // Every lane moves one bank up
			inv_next[l] = rd_inv[(l + `SHUF_SIMD - 1) % `SHUF_SIMD];
		end
	end

	// --------------------
	// Lane addresses and bank pattern
	always_ff @(posedge clk) begin
		if (rst) begin
			lane_addr <= RD_ADDR_INIT;
			rd_pat <= RD_INIT_PAT;
			rd_inv <= RD_INIT_INV;
		end else if (rd_go) begin
			if (page_end) begin
				lane_addr <= RD_ADDR_INIT; // Start of the next page
				rd_pat <= RD_INIT_PAT;
				rd_inv <= RD_INIT_INV;
			end else if (row_last) begin
				// Back to the top rows, one column right
				for (int l = 0; l < `SHUF_SIMD; l++) begin
					lane_addr[l] <= lane_addr[l] - COL_REWIND + bank_addr_t'(hor_inc[l]);
				end
				rd_pat <= pat_next;
				rd_inv <= inv_next;
			end else begin
				for (int l = 0; l < `SHUF_SIMD; l++) begin
					lane_addr[l] <= lane_addr[l] + ROW_STEP;
				end
			end
		end
	end

	assign page_base = rd_page ? bank_addr_t'(PAGE_WORDS) : '0;

	always_comb begin
		for (int b = 0; b < `SHUF_SIMD; b++) begin
			rd_addr[b] = page_base + lane_addr[rd_inv[b]];
		end
	end

	// --------------------
	// Output stage, beat held while obuf_rdy is low
	always_ff @(posedge clk) begin
		if (rst) obuf_vld <= 1'b0;
		else if (rd_go) obuf_vld <= 1'b1;
		else if (obuf_rdy) obuf_vld <= 1'b0; // Pending beat taken
	end

	always_ff @(posedge clk) begin
		if (rd_go) rd_pat_q <= rd_pat;
	end

	always_comb begin
		for (int l = 0; l < `SHUF_SIMD; l++) begin
			obuf_dat[l] = bank_q[rd_pat_q[l]];
		end
	end

endmodule

/* hw/page_ctrl.sv */
// --------------------
// Page control
// Empty/full state of both bank pages, input and read permission
// --------------------
`timescale 1ns/1ns

module page_ctrl
	import shuffle_pkg::*;
(
	input logic clk,
	input logic rst,

	input logic wr_page_done, // Pulse from write_sched
	input logic wr_page,
	input logic rd_page_done, // Last read of rd_page issued

	output logic irdy,
	output logic rd_allowed,
	output logic rd_page // Page being read
);

	page_e page_state [2];
	logic both_full;
	logic closing; // Page about to fill while the other one is still full

	always_ff @(posedge clk) begin
		if (rst) begin
			page_state[0] <= PAGE_EMPTY;
			page_state[1] <= PAGE_EMPTY;
			rd_page <= 1'b0;
		end else begin
			if (wr_page_done) page_state[wr_page] <= PAGE_FULL;
			// Never the same page as the write above
			if (rd_page_done) begin
				page_state[rd_page] <= PAGE_EMPTY;
				rd_page <= ~rd_page;
			end
		end
	end

	assign both_full = (page_state[0] == PAGE_FULL) && (page_state[1] == PAGE_FULL);
	assign closing = wr_page_done && (page_state[~wr_page] == PAGE_FULL);

	assign irdy = !both_full && !closing; // Writer already points at the other page
	assign rd_allowed = (page_state[rd_page] == PAGE_FULL);

endmodule

/* hw/write_sched.sv */
// --------------------
// Write scheduler
// Sequential write address over both pages and periodic unit rotation
// of the input lanes so every column slice lands in distinct banks
// --------------------
`timescale 1ns/1ns
`include "shuffle_settings.svh"

module write_sched
	import shuffle_pkg::*;
(
	input logic clk,
	input logic rst,

	input beat_t idat, // Row-major input beat
	input logic ivld,
	input logic irdy,

	output bank_wr_t bank_wr, // To all banks
	output logic wr_page_done, // One cycle pulse when a page is finished
	output logic wr_page // Page that finished
);

	typedef logic [$clog2(WR_ROT_PERIOD+1)-1:0] rep_t;

	localparam rep_t REP_LAST = rep_t'(WR_ROT_PERIOD - 1);
	localparam lane_t ROT_LAST = lane_t'(WR_ROTATIONS - 1);
	localparam bank_addr_t PAGE0_LAST = bank_addr_t'(PAGE_WORDS - 1);
	localparam bank_addr_t PAGE1_LAST = bank_addr_t'(BANK_DEPTH - 1);

	logic wr_fire; // Beat accepted this cycle
	bank_addr_t wr_addr; // 0 .. 2*PAGE_WORDS-1
	rep_t rep_cnt; // Writes since the last rotation
	lane_t rot_cnt; // Current lane offset up to WR_ROTATIONS-1
	logic rotate;

	assign wr_fire = ivld && irdy;
	assign rotate = (rep_cnt == REP_LAST); // Last write before the next rotation

	// --------------------
	// Address and rotation counters
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_addr <= '0;
			rep_cnt <= '0;
			rot_cnt <= '0;
		end else if (wr_fire) begin
			wr_addr <= (wr_addr == PAGE1_LAST) ? '0 : wr_addr + bank_addr_t'(1);
			rep_cnt <= rotate ? '0 : rep_cnt + rep_t'(1);
			if (rotate) begin
				rot_cnt <= (rot_cnt == ROT_LAST) ? '0 : rot_cnt + lane_t'(1);
			end
		end
	end

	// Bank b takes lane b-rot_cnt and is written on the accept edge
	always_comb begin
		bank_wr.en = wr_fire;
		bank_wr.addr = wr_addr;
		for (int b = 0; b < `SHUF_SIMD; b++) begin
			bank_wr.dat[b] = idat[(b + `SHUF_SIMD - int'(rot_cnt)) % `SHUF_SIMD];
		end
	end

	// --------------------
	// Page completion
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_page_done <= 1'b0;
			wr_page <= 1'b0;
		end else begin
			wr_page_done <= wr_fire && (wr_addr == PAGE0_LAST || wr_addr == PAGE1_LAST);
			if (wr_fire && wr_addr == PAGE0_LAST) wr_page <= 1'b0;
			if (wr_fire && wr_addr == PAGE1_LAST) wr_page <= 1'b1;
		end
	end

endmodule

/* hw/bank_array.sv */
// --------------------
// Bank array
// SIMD two-page memories, one common write port,
// separate read address per bank, registered read
// --------------------
`timescale 1ns/1ns
`include "shuffle_settings.svh"

module bank_array
	import shuffle_pkg::*;
(
	input logic clk,

	input bank_wr_t bank_wr, // Common write port

	input logic rd_en, // Read strobe for all banks
	input bank_addr_vec_t rd_addr, // One address per bank
	output beat_t bank_q // Bank b on element b
);

	// --------------------
	// One memory per bank
	for (genvar b = 0; b < `SHUF_SIMD; b++) begin : gen_bank
		elem_t mem [BANK_DEPTH]; // Page 0 low, page 1 high
		elem_t q; // Read data register

		always_ff @(posedge clk) begin
			if (bank_wr.en) begin
				mem[bank_wr.addr] <= bank_wr.dat[b];
			end
			// Old data when the same word is written on this edge
			if (rd_en) begin
				q <= mem[rd_addr[b]];
			end
		end

		assign bank_q[b] = q;
	end

endmodule

/* hw/shuffle_pkg.sv */
// --------------------
// Transpose unit types
// Beat and bank types, page state and the constant read patterns
// --------------------
`include "shuffle_settings.svh"

package shuffle_pkg;

	typedef logic [`SHUF_BITS-1:0] elem_t;
	typedef elem_t [`SHUF_SIMD-1:0] beat_t; // One beat, lane 0 is the lowest element
	typedef logic [$clog2(`SHUF_SIMD)-1:0] lane_t; // Bank or lane index
	typedef lane_t [`SHUF_SIMD-1:0] lane_vec_t; // Bank for each lane

	function automatic int unsigned gcd(int unsigned a, int unsigned b);
		return (b == 0) ? a : gcd(b, a % b);
	endfunction

	localparam int unsigned PAGE_WORDS = `SHUF_I * `SHUF_J / `SHUF_SIMD; // Words per bank page
	localparam int unsigned BANK_DEPTH = 2 * PAGE_WORDS; // Two pages per bank
	localparam int unsigned WR_ROTATIONS = gcd(`SHUF_J, `SHUF_SIMD); // Distinct lane rotations
	localparam int unsigned WR_ROT_PERIOD = `SHUF_J / WR_ROTATIONS; // Writes between rotations
	localparam int unsigned RD_ROT_PERIOD = `SHUF_I / `SHUF_SIMD; // Reads per column

	typedef logic [$clog2(BANK_DEPTH)-1:0] bank_addr_t;
	typedef bank_addr_t [`SHUF_SIMD-1:0] bank_addr_vec_t;

	// Shared write port of all banks
	typedef struct packed {
		logic en;
		bank_addr_t addr;
		beat_t dat; // Already rotated onto the banks
	} bank_wr_t;

	typedef enum logic {PAGE_EMPTY, PAGE_FULL} page_e;

	// Bank that holds lane l of column 0
	function automatic lane_vec_t init_rd_pattern();
		lane_vec_t pat;
		for (int l = 0; l < `SHUF_SIMD; l++) begin
			pat[l] = lane_t'((l * `SHUF_J + (l * WR_ROTATIONS) / `SHUF_SIMD) % `SHUF_SIMD);
		end
		return pat;
	endfunction

	// Lane served by each bank
	function automatic lane_vec_t inv_rd_pattern(lane_vec_t pat);
		lane_vec_t inv = '0;
		for (int b = 0; b < `SHUF_SIMD; b++) begin
			for (int l = 0; l < `SHUF_SIMD; l++) begin
				if (int'(pat[l]) == b) inv[b] = lane_t'(l); // Pattern is a permutation
			end
		end
		return inv;
	endfunction

	// Next column reads bank pat[l]+1, found as the entry perm[l] of this column
	function automatic lane_vec_t rd_perm_pattern();
		lane_vec_t pat;
		lane_vec_t inv;
		lane_vec_t perm;
		pat = init_rd_pattern();
		inv = inv_rd_pattern(pat);
		for (int l = 0; l < `SHUF_SIMD; l++) begin
			perm[l] = inv[(int'(pat[l]) + 1) % `SHUF_SIMD];
		end
		return perm;
	endfunction

	// Word of row l, column 0 within a page
	function automatic bank_addr_vec_t init_rd_addr();
		bank_addr_vec_t a;
		for (int l = 0; l < `SHUF_SIMD; l++) begin
			a[l] = bank_addr_t'((l * `SHUF_J) / `SHUF_SIMD);
		end
		return a;
	endfunction

endpackage

/* hw/shuffle_settings.svh */
// --------------------
// Transpose unit dimensions
// Element width, lane count and job matrix size, fixed at build time
// --------------------
`ifndef SHUFFLE_SETTINGS_SVH
`define SHUFFLE_SETTINGS_SVH

// Width of one matrix element
`define SHUF_BITS 8

// Lanes per beat, also the number of memory banks
`define SHUF_SIMD 4

// Rows per job, has to be a multiple of SHUF_SIMD
`define SHUF_I 8

// Columns per job
`define SHUF_J 6

`endif
